//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

   // data and address word
   typedef logic [31:0] word_t;

   // register index, r15 is the PC
   typedef logic [3:0] reg_idx_t;

   // carry, sign, zero, overflow
   typedef logic [3:0] flags_t;

   typedef enum logic [3:0] {
      alu_add = 4'd0,
      alu_adc = 4'd1,   // add with stored carry
      alu_sub = 4'd2,
      alu_sbc = 4'd3,   // subtract with stored carry
      alu_and = 4'd4,
      alu_or  = 4'd5,
      alu_xor = 4'd6,
      alu_mov = 4'd7,
      alu_shl = 4'd8,
      alu_shr = 4'd9,
      alu_cmp = 4'd10,  // sub without writeback
      alu_tst = 4'd11   // and without writeback
   } alu_op_t;

   // instruction class in bits 27:25
   typedef enum logic [2:0] {
      op_alu_r = 3'd0,
      op_alu_i = 3'd1,
      op_call  = 3'd2,
      op_ext   = 3'd3,  // executes as nop
      op_st_r  = 3'd4,
      op_ld_r  = 3'd5,
      op_st_i  = 3'd6,
      op_ld_i  = 3'd7
   } opcode_t;

   typedef enum logic [2:0] {
      ph_idle  = 3'd0,
      ph_fetch = 3'd1,
      ph_exec  = 3'd2,
      ph_mem   = 3'd3,
      ph_wb    = 3'd4
   } phase_t;

   localparam int FLAG_C = 0;
   localparam int FLAG_S = 1;
   localparam int FLAG_Z = 2;
   localparam int FLAG_V = 3;

   localparam reg_idx_t PC_IDX   = 4'd15;
   localparam reg_idx_t LINK_IDX = 4'd14;

   localparam int MEM_AW = 8;  // 256 words

endpackage

`default_nettype wire

//--- source/phase_sched.sv
`timescale 1ns/1ps
`default_nettype none

module phase_sched
(
   input  wire              clk,
   input  wire              arst_n_i,
   input  wire              run_i,
   output cpu_pkg::phase_t  phase_o
);
   import cpu_pkg::*;

   phase_t state;
   phase_t state_nxt;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         state <= ph_idle;
      else
         state <= state_nxt;
   end

   // run_i only sampled in idle and at the end of writeback
   always_comb
   begin
      case (state)
         ph_idle:  state_nxt = run_i ? ph_fetch : ph_idle;
         ph_fetch: state_nxt = ph_exec;
         ph_exec:  state_nxt = ph_mem;
         ph_mem:   state_nxt = ph_wb;
         ph_wb:    state_nxt = run_i ? ph_fetch : ph_idle;
         default:  state_nxt = ph_idle;
      endcase
   end

   assign phase_o = state;

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
(
   input  wire                clk,
   input  wire                arst_n_i,
   input  wire cpu_pkg::reg_idx_t ra_i,
   input  wire cpu_pkg::reg_idx_t rb_i,
   input  wire cpu_pkg::reg_idx_t rd_i,
   input  wire cpu_pkg::reg_idx_t rw_i,  // writeback target
   input  wire cpu_pkg::reg_idx_t rt_i,  // test read select
   input  wire                inc_pc_i,
   input  wire                link_i,
   input  wire                base_upd_i,
   input  wire                wb_i,
   input  wire cpu_pkg::word_t base_data_i,
   input  wire cpu_pkg::word_t wb_data_i,
   output cpu_pkg::word_t     da_o,
   output cpu_pkg::word_t     db_o,
   output cpu_pkg::word_t     dd_o,
   output cpu_pkg::word_t     dt_o,
   output cpu_pkg::word_t     pc_o
);
   import cpu_pkg::*;

   word_t regs [0:15];

   // write causes come in different phases, never together
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         for (int i = 0; i < 16; i++)
            regs[i] <= '0;
      end
      else
      begin
         if (inc_pc_i)
            regs[PC_IDX] <= regs[PC_IDX] + 32'd1;
         if (link_i)
            regs[LINK_IDX] <= regs[PC_IDX];  // PC already incremented here
         if (base_upd_i)
            regs[ra_i] <= base_data_i;
         if (wb_i)
            regs[rw_i] <= wb_data_i;
      end
   end

   assign da_o = regs[ra_i];
   assign db_o = regs[rb_i];
   assign dd_o = regs[rd_i];
   assign dt_o = regs[rt_i];
   assign pc_o = regs[PC_IDX];

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
(
   input  wire cpu_pkg::alu_op_t op_i,
   input  wire cpu_pkg::flags_t  flags_i,
   input  wire cpu_pkg::word_t   a_i,
   input  wire cpu_pkg::word_t   b_i,
   output cpu_pkg::word_t        res_o,
   output cpu_pkg::flags_t       flags_o,
   output logic                  wb_en_o,
   output logic                  flag_en_o
);
   import cpu_pkg::*;

   logic        sub_op;
   logic        cin;
   word_t       b_add;
   logic [32:0] sum;
   logic [32:0] shl_full;
   logic [32:0] shr_full;
   logic        carry;
   logic        ovf;

   // subtraction as a + ~b + cin, so carry set means no borrow
   assign sub_op = op_i inside {alu_sub, alu_sbc, alu_cmp};
   assign b_add  = sub_op ? ~b_i : b_i;
   assign cin    = (op_i == alu_adc || op_i == alu_sbc) ? flags_i[FLAG_C] : sub_op;
   assign sum    = {1'b0, a_i} + {1'b0, b_add} + 33'(cin);

   assign shl_full = {1'b0, a_i} << b_i[4:0];  // bit 32 is the last bit out
   assign shr_full = {a_i, 1'b0} >> b_i[4:0];  // bit 0 is the last bit out

   always_comb
   begin
      res_o = b_i;              // mov and unused codes
      carry = flags_i[FLAG_C];
      ovf   = flags_i[FLAG_V];
      case (op_i)
         alu_add, alu_adc, alu_sub, alu_sbc, alu_cmp:
         begin
            res_o = sum[31:0];
            carry = sum[32];
            ovf   = (a_i[31] == b_add[31]) && (sum[31] != a_i[31]);
         end
         alu_and, alu_tst:
            res_o = a_i & b_i;
         alu_or:
            res_o = a_i | b_i;
         alu_xor:
            res_o = a_i ^ b_i;
         alu_shl:
         begin
            res_o = shl_full[31:0];
            carry = shl_full[32];
         end
         alu_shr:
         begin
            res_o = shr_full[32:1];
            carry = shr_full[0];
         end
         default:
            res_o = b_i;
      endcase
      flags_o         = '0;
      flags_o[FLAG_C] = carry;
      flags_o[FLAG_S] = res_o[31];
      flags_o[FLAG_Z] = (res_o == '0);
      flags_o[FLAG_V] = ovf;
   end

   assign wb_en_o   = !(op_i inside {alu_cmp, alu_tst});
   assign flag_en_o = (op_i != alu_mov) && (op_i <= alu_tst);

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core
(
   input  wire                    clk,
   input  wire                    arst_n_i,
   input  wire                    run_i,
   output cpu_pkg::word_t         bus_addr_o,
   output cpu_pkg::word_t         bus_wdata_o,
   input  wire cpu_pkg::word_t    bus_rdata_i,
   output logic                   bus_we_o,
   input  wire cpu_pkg::reg_idx_t test_rsel_i,
   output cpu_pkg::word_t         test_reg_o,
   output cpu_pkg::phase_t        phase_o
);
   import cpu_pkg::*;

   phase_t   phase;
   word_t    ir;
   flags_t   flags;
   word_t    ld_data;
   word_t    pc;
   word_t    opa;
   word_t    opb;
   word_t    opd;
   word_t    alu_b;
   word_t    alu_res;
   flags_t   alu_flags;
   logic     alu_wb_en;
   logic     alu_flag_en;
   opcode_t  opcode;
   reg_idx_t rd;
   reg_idx_t ra;
   reg_idx_t rb;
   reg_idx_t wb_idx;
   word_t    sext_im16;
   word_t    sext_im20;
   word_t    step;
   word_t    ra_stepped;
   word_t    ldst_addr;
   word_t    call_target;
   word_t    wb_data;
   logic     ena;
   logic     inst_alu;
   logic     inst_call;
   logic     inst_ld;
   logic     inst_st;
   logic     inst_mem_r;
   logic     inst_wb;

   phase_sched i_sched (.clk, .arst_n_i, .run_i, .phase_o(phase));

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         ir <= '0;
      else if (phase == ph_fetch)
         ir <= bus_rdata_i;
   end

   assign opcode    = opcode_t'(ir[27:25]);
   assign rd        = ir[23:20];
   assign ra        = ir[19:16];  // also the alu op
   assign rb        = ir[11:8];
   assign sext_im16 = {{16{ir[15]}}, ir[15:0]};
   assign sext_im20 = {{12{ir[19]}}, ir[19:0]};

   assign inst_alu   = opcode inside {op_alu_r, op_alu_i};
   assign inst_call  = (opcode == op_call);
   assign inst_ld    = opcode inside {op_ld_r, op_ld_i};
   assign inst_st    = opcode inside {op_st_r, op_st_i};
   assign inst_mem_r = opcode inside {op_ld_r, op_st_r};
   assign inst_wb    = (inst_alu & alu_wb_en) | inst_call | inst_ld;

   // condition against stored flags
   always_comb
   begin
      case (ir[31:28])
         4'h1: ena = flags[FLAG_Z];                                         // eq
         4'h2: ena = !flags[FLAG_Z];                                        // ne
         4'h3: ena = flags[FLAG_C];                                         // cs
         4'h4: ena = !flags[FLAG_C];                                        // cc
         4'h5: ena = flags[FLAG_S];                                         // mi
         4'h6: ena = !flags[FLAG_S];                                        // pl
         4'h7: ena = flags[FLAG_V];                                         // vs
         4'h8: ena = !flags[FLAG_V];                                        // vc
         4'h9: ena = flags[FLAG_C] & !flags[FLAG_Z];                        // hi
         4'ha: ena = !flags[FLAG_C] | flags[FLAG_Z];                        // ls
         4'hb: ena = !(flags[FLAG_S] ^ flags[FLAG_V]);                      // ge
         4'hc: ena = flags[FLAG_S] ^ flags[FLAG_V];                         // lt
         4'hd: ena = !flags[FLAG_Z] & !(flags[FLAG_S] ^ flags[FLAG_V]);     // gt
         4'he: ena = flags[FLAG_Z] | (flags[FLAG_S] ^ flags[FLAG_V]);       // le
         default: ena = 1'b1;  // 0 and 15 always
      endcase
   end

   assign alu_b = (opcode == op_alu_i) ? sext_im16 : opb;

   alu i_alu (.op_i(alu_op_t'(ra)), .flags_i(flags), .a_i(opd), .b_i(alu_b), .res_o(alu_res),
              .flags_o(alu_flags), .wb_en_o(alu_wb_en), .flag_en_o(alu_flag_en));

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         flags <= '0;
      else if (ena && inst_alu && alu_flag_en && phase == ph_wb)
         flags <= alu_flags;
   end

   // load/store address
   assign step       = ir[15] ? 32'd1 : '1;
   assign ra_stepped = opa + step;
   assign ldst_addr  = inst_mem_r ? ((ir[14] ? ra_stepped : opa) + opb) : (opa + sext_im16);

   assign call_target = ir[24] ? (opd + sext_im20) : {8'd0, ir[23:0]};

   always_ff @(posedge clk)
   begin
      if (phase == ph_mem && inst_ld)
         ld_data <= bus_rdata_i;
   end

   assign wb_idx  = inst_call ? PC_IDX : rd;
   assign wb_data = inst_call ? call_target : (inst_ld ? ld_data : alu_res);

   reg_file i_regs (
      .clk, .arst_n_i,
      .ra_i(ra), .rb_i(rb), .rd_i(rd), .rw_i(wb_idx), .rt_i(test_rsel_i),
      .inc_pc_i(phase == ph_exec),
      .link_i(ena && inst_call && phase == ph_mem),
      .base_upd_i(ena && inst_mem_r && ir[24] && phase == ph_mem),
      .wb_i(ena && inst_wb && phase == ph_wb),
      .base_data_i(ra_stepped), .wb_data_i(wb_data),
      .da_o(opa), .db_o(opb), .dd_o(opd), .dt_o(test_reg_o), .pc_o(pc)
   );

   // bus address is the PC except for a taken access in mem
   always_comb
   begin
      bus_addr_o = pc;
      if (phase == ph_mem && ena && (inst_ld || inst_st))
         bus_addr_o = ldst_addr;
   end

   assign bus_wdata_o = opd;
   assign bus_we_o    = ena && inst_st && (phase == ph_mem);
   assign phase_o     = phase;

endmodule

`default_nettype wire

//--- source/sys_mem.sv
`timescale 1ns/1ps
`default_nettype none

module sys_mem
(
   input  wire                            clk,
   input  wire cpu_pkg::word_t            addr_i,
   input  wire cpu_pkg::word_t            wdata_i,
   input  wire                            we_i,
   output cpu_pkg::word_t                 rdata_o,
   input  wire [cpu_pkg::MEM_AW-1:0]      ld_addr_i,
   input  wire cpu_pkg::word_t            ld_data_i,
   input  wire                            ld_we_i,
   output cpu_pkg::word_t                 ld_rdata_o
);
   import cpu_pkg::*;

   word_t mem [0:(1 << MEM_AW)-1];

   // core write wins over the load port
   always_ff @(posedge clk)
   begin
      if (we_i)
         mem[addr_i[MEM_AW-1:0]] <= wdata_i;
      else if (ld_we_i)
         mem[ld_addr_i] <= ld_data_i;
   end

   assign rdata_o    = mem[addr_i[MEM_AW-1:0]];  // upper address bits ignored
   assign ld_rdata_o = mem[ld_addr_i];

endmodule

`default_nettype wire

//--- source/cpu_sys.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_sys
(
   input  wire                        clk,
   input  wire                        arst_n_i,
   input  wire                        run_i,
   input  wire [cpu_pkg::MEM_AW-1:0]  ld_addr_i,
   input  wire cpu_pkg::word_t        ld_data_i,
   input  wire                        ld_we_i,
   output cpu_pkg::word_t             ld_rdata_o,
   input  wire cpu_pkg::reg_idx_t     test_rsel_i,
   output cpu_pkg::word_t             test_reg_o,
   output cpu_pkg::phase_t            phase_o
);
   import cpu_pkg::*;

   word_t bus_addr;
   word_t bus_wdata;
   word_t bus_rdata;
   logic  bus_we;

   cpu_core i_core (
      .clk, .arst_n_i, .run_i,
      .bus_addr_o(bus_addr), .bus_wdata_o(bus_wdata), .bus_rdata_i(bus_rdata),
      .bus_we_o(bus_we),
      .test_rsel_i, .test_reg_o, .phase_o
   );

   sys_mem i_mem (
      .clk,
      .addr_i(bus_addr), .wdata_i(bus_wdata), .we_i(bus_we), .rdata_o(bus_rdata),
      .ld_addr_i, .ld_data_i, .ld_we_i, .ld_rdata_o
   );

endmodule

`default_nettype wire

//--- test/tb_cpu_sys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_sys;
   import cpu_pkg::*;

   logic              clk;
   logic              arst_n;
   logic              run;
   logic [MEM_AW-1:0] ld_addr;
   word_t             ld_data;
   logic              ld_we;
   word_t             ld_rdata;
   reg_idx_t          test_rsel;
   word_t             test_reg;
   phase_t            phase;

   logic [7:0] rec_tag [$];  // one entry per pattern record
   word_t      rec_a [$];
   word_t      rec_b [$];
   int         cycles = 0;
   int         limit = 1000000;

   cpu_sys i_dut (
      .clk, .arst_n_i(arst_n), .run_i(run),
      .ld_addr_i(ld_addr), .ld_data_i(ld_data), .ld_we_i(ld_we), .ld_rdata_o(ld_rdata),
      .test_rsel_i(test_rsel), .test_reg_o(test_reg), .phase_o(phase)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > limit)
      begin
         $display("timeout, the run went past %0d clock cycles", limit);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   task automatic check(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         $display("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic read_patterns();
      int         fd;
      int         code;
      logic [7:0] tag;
      word_t      a;
      word_t      b;
      string      line;
      fd = $fopen("test/cpu_patterns.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open the pattern file test/cpu_patterns.txt");
         $display("TEST FAILED");
         $fatal(1, "missing pattern file");
      end
      else
      begin
         while (!$feof(fd))
         begin
            a = '0;
            b = '0;
            code = $fscanf(fd, " %c", tag);
            if (code == 1 && tag == "#")
               code = $fgets(line, fd);  // skip comment line
            else if (code == 1)
            begin
               if (tag == "R")
                  code = $fscanf(fd, " %h", a);
               else
                  code = $fscanf(fd, " %h %h", a, b);
               rec_tag.push_back(tag);
               rec_a.push_back(a);
               rec_b.push_back(b);
            end
         end
         $fclose(fd);
      end
   endtask

   // phase must stay idle and every register read zero after reset
   task automatic reset_cpu();
      @(posedge clk);
      #1;
      arst_n = 1'b0;
      run    = 1'b0;
      repeat (2) @(posedge clk);
      #1 arst_n = 1'b1;
      repeat (2)
      begin
         @(posedge clk);
         #1 check("phase_o", 32'(phase), 32'(ph_idle));
      end
      for (int r = 0; r < 16; r++)
      begin
         @(posedge clk);
         #1 test_rsel = 4'(r);
         #1 check($sformatf("r%0d", r), test_reg, '0);
      end
   endtask

   task automatic load_word(input word_t addr, input word_t data);
      @(posedge clk);
      #1;
      ld_addr = addr[MEM_AW-1:0];
      ld_data = data;
      ld_we   = 1'b1;  // written at the next edge
   endtask

   task automatic run_program(input word_t n);
      @(posedge clk);
      #1;
      ld_we = 1'b0;
      run   = 1'b1;
      repeat (n) @(posedge clk);
      #1 run = 1'b0;
      while (phase != ph_idle)  // current instruction finishes first
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_reg(input word_t idx, input word_t exp);
      @(posedge clk);
      #1 test_rsel = idx[3:0];
      #1 check($sformatf("r%0d", idx), test_reg, exp);
   endtask

   task automatic check_mem(input word_t addr, input word_t exp);
      @(posedge clk);
      #1 ld_addr = addr[MEM_AW-1:0];
      #1 check($sformatf("mem[%0h]", addr), ld_rdata, exp);
   endtask

   initial
   begin
      logic ran;
      arst_n    = 1'b1;
      run       = 1'b0;
      ld_addr   = '0;
      ld_data   = '0;
      ld_we     = 1'b0;
      test_rsel = '0;
      ran       = 1'b0;
      read_patterns();
      limit = 200;
      foreach (rec_tag[i])
         limit += (rec_tag[i] == "R") ? int'(rec_a[i]) : 1;
      reset_cpu();
      foreach (rec_tag[i])
      begin
         case (rec_tag[i])
            "P":
            begin
               if (ran)  // a new program group starts
               begin
                  reset_cpu();
                  ran = 1'b0;
               end
               load_word(rec_a[i], rec_b[i]);
            end
            "R":
            begin
               run_program(rec_a[i]);
               ran = 1'b1;
            end
            "X": check_reg(rec_a[i], rec_b[i]);
            "M": check_mem(rec_a[i], rec_b[i]);
            default:
            begin
               $display("unknown record tag %c in the pattern file", rec_tag[i]);
               $display("TEST FAILED");
               $fatal(1, "bad pattern file");
            end
         endcase
      end
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- test/cpu_patterns.txt
# records, all values hex: P addr word = load memory, R cycles = run,
# X reg value = expected register, M addr value = expected memory word
# program 1: alu ops, adc/sbc, cmp with eq ne lt ge hi, mov keeps flags
P 00 0217FFFF
P 01 02270001
P 02 00100200
P 03 02370005
P 04 02310002
P 05 0247000A
P 06 02430003
P 07 024A0006
P 08 12570011
P 09 22670022
P 0A 024A0007
P 0B C2770033
P 0C B2870044
P 0D 02970001
P 0E C2900010
P 0F 022A0000
P 10 92A70055
P 11 022A0001
P 12 92B70066
P 13 02F70013
R 60
X 1 00000000
X 2 00000001
X 3 00000008
X 4 00000006
X 5 00000011
X 6 00000000
X 7 00000033
X 8 00000000
X 9 00000011
X A 00000055
X B 00000000
X F 00000013
# program 2: load/store both forms, calls, jumps through r15
P 00 02170080
P 01 02271234
P 02 0C21FFFE
P 03 0E31FFFF
P 04 02670090
P 05 09268000
P 06 0916C000
P 07 09364000
P 08 02570004
P 09 08560500
P 0A 028700A1
P 0B 0B988000
P 0C 0AA8C000
P 0D 0BB80000
P 0E 0AC84000
P 0F 04000011
P 10 02D70BAD
P 11 051FFF93
P 12 02D70BAD
P 13 0EF0007D
P 14 02D70BAD
P 15 02F00001
P 16 02D70BAD
P 17 0277600D
P 18 02F70018
P 7D 00000015
P 7F CAFE0001
P A0 0000A000
P A1 0000A001
P A2 0000A002
P A3 0000A003
R 70
X 1 00000080
X 2 00001234
X 3 CAFE0001
X 5 00000004
X 6 00000091
X 7 0000600D
X 8 000000A1
X 9 0000A001
X A 0000A003
X B 0000A002
X C 0000A000
X D 00000000
X E 00000012
X F 00000018
M 7E 00001234
M 90 00001234
M 91 CAFE0001
M 92 00000080
M 95 00000004

//--- sources.f
source/cpu_pkg.sv
source/phase_sched.sv
source/reg_file.sv
source/alu.sv
source/cpu_core.sv
source/sys_mem.sv
source/cpu_sys.sv
test/tb_cpu_sys.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_cpu_sys -f sources.f \
   --Mdir obj_dir -o tb_cpu_sys
./obj_dir/tb_cpu_sys | tee sim.log
if grep -q "^TEST PASSED$" sim.log
then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
